// File: arbiter/flitTimer.sv
`timescale 1ns/1ps

module flitTimer
  import nocArbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  flitId_e             flitId,
  input  logic [LenWidth-1:0] length,
  input  logic                run,
  output logic                timesUp
);

  logic [LenWidth-1:0] limit;
  logic [LenWidth-1:0] count;

  // hold limit comes from the header flit only
  always_ff @(posedge clk)
  begin
    if (rst)
      limit <= '0;
    else if (flitId == Header)
      limit <= length;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (run)
      count <= count + 1'b1;
    else
      count <= '0;   // any cycle off the link restarts the count
  end

  // a zero limit expires on the first granted cycle
  assign timesUp = (count == limit);

endmodule

// File: arbiter/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
  import nocArbPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                arbEnable,
  input  logic                lReq,
  input  logic                nReq,
  input  logic                eReq,
  input  logic                wReq,
  input  logic                sReq,
  input  flitId_e             lFlitId,
  input  flitId_e             nFlitId,
  input  flitId_e             eFlitId,
  input  flitId_e             wFlitId,
  input  flitId_e             sFlitId,
  input  logic [LenWidth-1:0] lLength,
  input  logic [LenWidth-1:0] nLength,
  input  logic [LenWidth-1:0] eLength,
  input  logic [LenWidth-1:0] wLength,
  input  logic [LenWidth-1:0] sLength,
  output logic [NumPorts-1:0] grant
);

  arbState_e state;
  arbState_e nextState;
  port_e holder;

  logic [NumPorts-1:0] gatedReq;
  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] timesUp;

  flitId_e flitIds [NumPorts];
  logic [LenWidth-1:0] lengths [NumPorts];

  // first requester among base, base+1, ... (span ports), wrapping after S
  function automatic arbState_e rotatePick(input logic [NumPorts-1:0] req,
                                           input int unsigned base,
                                           input int unsigned span);
    arbState_e pick;
    int unsigned idx;
    pick = StIdle;
    // walk backwards so the nearest requester is kept last
    for (int k = int'(span) - 1; k >= 0; k--)
    begin
      idx = (base + k) % NumPorts;
      if (req[idx])
        pick = arbState_e'(StL << idx);
    end
    return pick;
  endfunction

  function automatic port_e holderOf(input arbState_e st);
    case (st)
      StN:     return PortN;
      StE:     return PortE;
      StW:     return PortW;
      StS:     return PortS;
      default: return PortL;
    endcase
  endfunction

  assign gatedReq = {sReq, wReq, eReq, nReq, lReq} & {NumPorts{arbEnable}};

  assign flitIds = '{lFlitId, nFlitId, eFlitId, wFlitId, sFlitId};
  assign lengths = '{lLength, nLength, eLength, wLength, sLength};

  // timers and FSM form a loop: run out, timesUp back
  for (genvar i = 0; i < NumPorts; i++)
  begin : timer_g
    flitTimer flitTimer_i (
      .clk     (clk),
      .rst     (rst),
      .flitId  (flitIds[i]),
      .length  (lengths[i]),
      .run     (run[i]),
      .timesUp (timesUp[i])
    );
  end

  assign holder = holderOf(state);

  always_comb
  begin
    nextState = StIdle;
    run = '0;
    case (state)
      StIdle:
        nextState = rotatePick(gatedReq, 0, NumPorts);
      StL, StN, StE, StW, StS:
      begin
        if (gatedReq[holder] && !timesUp[holder])
        begin
          run[holder] = 1'b1;   // keep the link
          nextState = state;
        end
        else
          nextState = rotatePick(gatedReq, int'(holder) + 1, NumPorts - 1);
      end
      default:
        nextState = StIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= StIdle;
    else
      state <= nextState;
  end

  assign grant = state[NumPorts:1];   // drop the idle bit

endmodule

// File: common/nocArbPkg.sv
package nocArbPkg;

  localparam int NumPorts = 5;
  localparam int LenWidth = 12;     // packet length and timer count
  localparam int FlitIdWidth = 3;
  localparam int DataWidth = 16;
  localparam int CountWidth = 16;   // grant-cycle counters
  localparam int PortIdWidth = $clog2(NumPorts);

  // apb side
  localparam int AddrWidth = 5;
  localparam int ApbDataWidth = 32;
  localparam logic [AddrWidth-1:0] AddrCtrl = 5'h14;
  localparam logic [AddrWidth-1:0] AddrCnt0 = 5'h00;   // counter n at AddrCnt0 + 4n

  // cyclic priority order L, N, E, W, S
  typedef enum logic [PortIdWidth-1:0] {
    PortL = 0,
    PortN = 1,
    PortE = 2,
    PortW = 3,
    PortS = 4
  } port_e;

  typedef enum logic [FlitIdWidth-1:0] {
    Idle   = 3'd0,
    Header = 3'd1,
    Body   = 3'd2,
    Tail   = 3'd3
  } flitId_e;

  // one-hot, bits above StIdle line up with the grant vector
  typedef enum logic [NumPorts:0] {
    StIdle = 6'b000001,
    StL    = 6'b000010,
    StN    = 6'b000100,
    StE    = 6'b001000,
    StW    = 6'b010000,
    StS    = 6'b100000
  } arbState_e;

endpackage

// File: hdl/apbStatus.sv
`timescale 1ns/1ps

module apbStatus
  import nocArbPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [AddrWidth-1:0]    paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [ApbDataWidth-1:0] pwdata,
  input  logic [NumPorts-1:0]     grant,
  output logic [ApbDataWidth-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    arbEnable
);

  logic [CountWidth-1:0] grantCnt [NumPorts];
  logic [NumPorts-1:0] cntHit;
  logic ctrlHit;
  logic access;
  logic wrAccess;

  assign access = psel & penable;   // access phase
  assign wrAccess = access & pwrite;

  assign ctrlHit = (paddr == AddrCtrl);

  always_comb
  begin
    for (int n = 0; n < NumPorts; n++)
      cntHit[n] = (paddr == AddrWidth'(AddrCnt0 + 4 * n));
  end

  assign pready = 1'b1;   // no wait states
  assign pslverr = access & ~(ctrlHit | (|cntHit));

  // read data straight from the decoded register
  always_comb
  begin
    prdata = '0;
    if (ctrlHit)
      prdata[0] = arbEnable;
    for (int n = 0; n < NumPorts; n++)
    begin
      if (cntHit[n])
        prdata[CountWidth-1:0] = grantCnt[n];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      arbEnable <= 1'b0;
    else if (wrAccess && ctrlHit)
      arbEnable <= pwdata[0];
  end

  always_ff @(posedge clk)
  begin
    for (int n = 0; n < NumPorts; n++)
    begin
      if (rst)
        grantCnt[n] <= '0;
      else if (wrAccess && cntHit[n])
        grantCnt[n] <= '0;   // clear beats increment
      else if (grant[n] && (grantCnt[n] != '1))
        grantCnt[n] <= grantCnt[n] + 1'b1;   // saturate at all ones
    end
  end

endmodule

// File: hdl/flitSwitch.sv
`timescale 1ns/1ps

module flitSwitch
  import nocArbPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NumPorts-1:0]  grant,
  input  logic [DataWidth-1:0] lData,
  input  logic [DataWidth-1:0] nData,
  input  logic [DataWidth-1:0] eData,
  input  logic [DataWidth-1:0] wData,
  input  logic [DataWidth-1:0] sData,
  output logic                 outValid,
  output logic [DataWidth-1:0] outData
);

  logic [DataWidth-1:0] dataIn [NumPorts];
  logic [DataWidth-1:0] selData;

  assign dataIn = '{lData, nData, eData, wData, sData};

  // grant is one-hot, so at most one port matches
  always_comb
  begin
    selData = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
        selData = dataIn[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |grant;
  end

  // link data keeps its last flit while nobody is granted
  always_ff @(posedge clk)
  begin
    if (|grant)
      outData <= selData;
  end

endmodule

// File: hdl/routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort
  import nocArbPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    lReq,
  input  logic                    nReq,
  input  logic                    eReq,
  input  logic                    wReq,
  input  logic                    sReq,
  input  flitId_e                 lFlitId,
  input  flitId_e                 nFlitId,
  input  flitId_e                 eFlitId,
  input  flitId_e                 wFlitId,
  input  flitId_e                 sFlitId,
  input  logic [DataWidth-1:0]    lData,
  input  logic [DataWidth-1:0]    nData,
  input  logic [DataWidth-1:0]    eData,
  input  logic [DataWidth-1:0]    wData,
  input  logic [DataWidth-1:0]    sData,
  input  logic [AddrWidth-1:0]    paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [ApbDataWidth-1:0] pwdata,
  output logic [ApbDataWidth-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    outValid,
  output logic [DataWidth-1:0]    outData,
  output logic [NumPorts-1:0]     grant
);

  logic arbEnable;

  // header length rides in the low bits of the flit payload
  outputArbiter outputArbiter_i (
    .clk       (clk),
    .rst       (rst),
    .arbEnable (arbEnable),
    .lReq      (lReq),
    .nReq      (nReq),
    .eReq      (eReq),
    .wReq      (wReq),
    .sReq      (sReq),
    .lFlitId   (lFlitId),
    .nFlitId   (nFlitId),
    .eFlitId   (eFlitId),
    .wFlitId   (wFlitId),
    .sFlitId   (sFlitId),
    .lLength   (lData[LenWidth-1:0]),
    .nLength   (nData[LenWidth-1:0]),
    .eLength   (eData[LenWidth-1:0]),
    .wLength   (wData[LenWidth-1:0]),
    .sLength   (sData[LenWidth-1:0]),
    .grant     (grant)
  );

  flitSwitch flitSwitch_i (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lData    (lData),
    .nData    (nData),
    .eData    (eData),
    .wData    (wData),
    .sData    (sData),
    .outValid (outValid),
    .outData  (outData)
  );

  apbStatus apbStatus_i (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .grant     (grant),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .arbEnable (arbEnable)
  );

endmodule

// File: nocArb.f
common/nocArbPkg.sv
arbiter/flitTimer.sv
arbiter/outputArbiter.sv
hdl/flitSwitch.sv
hdl/apbStatus.sv
hdl/routerOutputPort.sv
tests/clockGen.sv
tests/routerOutputPort_asserts.sv
tests/routerOutputPort_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f nocArb.f \
  --top-module routerOutputPort_tb \
  -Mdir obj_dir

# the error limit keeps assertion failures from stopping the run early
out=$(./obj_dir/VrouterOutputPort_tb +verilator+error+limit+1000)
echo "$out"

grep -qx "Simulation passed" <<< "$out"

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: tests/routerOutputPort_asserts.sv
`timescale 1ns/1ps

module routerOutputPort_asserts
  import nocArbPkg::*;
#(
  parameter bit ApbSide = 1'b0   // apb side or arbiter side
)
(
  input logic                clk,
  input logic                rst,
  input logic [NumPorts-1:0] grant,
  input logic                arbEnable,
  input logic                psel,
  input logic                penable,
  input logic                pready
);

  int failCount = 0;

  if (ApbSide)
  begin : apb_g
    accessReady: assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
    else
    begin
      failCount++;
      $error("pready low during an access phase");
    end
  end
  else
  begin : grant_g
    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else
    begin
      failCount++;
      $error("grant has more than one bit set");
    end

    // requests are masked one cycle before the grant register
    disabledIdle: assert property (@(posedge clk) disable iff (rst) !arbEnable |=> (grant == '0))
    else
    begin
      failCount++;
      $error("grant set although the arbiter was disabled");
    end
  end

endmodule

bind apbStatus routerOutputPort_asserts #(.ApbSide(1'b1)) apbAsserts_i (
  .clk       (clk),
  .rst       (rst),
  .grant     (grant),
  .arbEnable (arbEnable),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready)
);

bind outputArbiter routerOutputPort_asserts #(.ApbSide(1'b0)) arbAsserts_i (
  .clk       (clk),
  .rst       (rst),
  .grant     (grant),
  .arbEnable (arbEnable),
  .psel      (1'b0),
  .penable   (1'b0),
  .pready    (1'b1)
);

// File: tests/routerOutputPort_tb.sv
`timescale 1ns/1ps

module routerOutputPort_tb;
  import nocArbPkg::*;

  logic clk;
  logic rst;
  logic [NumPorts-1:0] req;
  flitId_e fid [NumPorts];
  logic [DataWidth-1:0] pdata [NumPorts];
  logic [AddrWidth-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [ApbDataWidth-1:0] pwdata;
  logic [ApbDataWidth-1:0] prdata;
  logic pready;
  logic pslverr;
  logic outValid;
  logic [DataWidth-1:0] outData;
  logic [NumPorts-1:0] grant;

  logic [31:0] seed = 32'hf156_d781;
  int errors = 0;
  int assertFails;
  logic [NumPorts-1:0] expGrant;
  logic expErr;

  // model state
  int mHold;   // -1 while idle
  int mCount [NumPorts];
  int mLimit [NumPorts];
  logic mOutValid;
  logic [DataWidth-1:0] mOutData;
  logic [CountWidth-1:0] mCnt [NumPorts];
  logic mEnable;

  clockGen clockGen_i (.clk(clk), .rst(rst));

  routerOutputPort routerOutputPort_i (
    .clk(clk), .rst(rst),
    .lReq(req[0]), .nReq(req[1]), .eReq(req[2]), .wReq(req[3]), .sReq(req[4]),
    .lFlitId(fid[0]), .nFlitId(fid[1]), .eFlitId(fid[2]), .wFlitId(fid[3]), .sFlitId(fid[4]),
    .lData(pdata[0]), .nData(pdata[1]), .eData(pdata[2]), .wData(pdata[3]), .sData(pdata[4]),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .outValid(outValid), .outData(outData), .grant(grant)
  );

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // one clock of FSM, timers, switch register and counters
  function automatic void stepModel();
    logic [NumPorts-1:0] gated;
    int next;
    int start;
    int span;
    int p;
    if (rst)
    begin
      mHold = -1;
      mOutValid = 1'b0;
      mEnable = 1'b0;
      for (int i = 0; i < NumPorts; i++)
      begin
        mCount[i] = 0;
        mLimit[i] = 0;
        mCnt[i] = '0;
      end
      return;
    end
    gated = req & {NumPorts{mEnable}};
    next = -1;
    start = (mHold < 0) ? 0 : mHold + 1;
    span = (mHold < 0) ? NumPorts : NumPorts - 1;
    if (mHold >= 0 && gated[mHold] && mCount[mHold] != mLimit[mHold])
      next = mHold;
    else
      for (int k = 0; k < span; k++)
      begin
        p = (start + k) % NumPorts;
        if (gated[p] && next < 0)
          next = p;
      end
    for (int i = 0; i < NumPorts; i++)
    begin
      mCount[i] = (i == mHold && next == mHold) ? mCount[i] + 1 : 0;
      if (fid[i] == Header)
        mLimit[i] = int'(pdata[i][LenWidth-1:0]);
      if (psel && penable && pwrite && paddr == AddrWidth'(4 * i))
        mCnt[i] = '0;
      else if (mHold == i && mCnt[i] != '1)
        mCnt[i] = mCnt[i] + 1'b1;
    end
    if (psel && penable && pwrite && paddr == AddrCtrl)
      mEnable = pwdata[0];
    if (mHold >= 0)
      mOutData = pdata[mHold];
    mOutValid = (mHold >= 0);
    mHold = next;
  endfunction

  function automatic logic [31:0] modelRead(input logic [AddrWidth-1:0] addr);
    if (addr == AddrCtrl)
      return {31'd0, mEnable};
    for (int i = 0; i < NumPorts; i++)
      if (addr == AddrWidth'(4 * i))
        return {16'd0, mCnt[i]};
    return 32'd0;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got)
    else
    begin
      errors++;
      $display("[ERROR] %s expected %h got %h at %0t", name, exp, got, $time);
    end
  endtask

  always @(posedge clk)
  begin
    stepModel();
    #1;   // let the registers settle
    expGrant = (mHold < 0) ? '0 : NumPorts'(1 << mHold);
    expErr = psel && penable
      && !(paddr == AddrCtrl || (paddr[1:0] == 2'b00 && paddr <= 5'h10));
    checkValue("grant", 32'(expGrant), 32'(grant));
    checkValue("outValid", 32'(mOutValid), 32'(outValid));
    if (mOutValid)
      checkValue("outData", 32'(mOutData), 32'(outData));
    checkValue("prdata", modelRead(paddr), prdata);
    checkValue("pslverr", 32'(expErr), 32'(pslverr));
    checkValue("pready", 32'd1, 32'(pready));
  end

  task automatic apbAccess(input logic write, input logic [AddrWidth-1:0] addr,
                           input logic [31:0] wdata);
    @(negedge clk);
    psel = 1'b1;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // header flits carry len in the low bits
  task automatic drivePorts(input logic [NumPorts-1:0] mask, input logic header, input int len);
    logic [31:0] r;
    @(negedge clk);
    for (int i = 0; i < NumPorts; i++)
    begin
      r = nextRand();
      req[i] = mask[i];
      fid[i] = !mask[i] ? Idle : (header ? Header : Body);
      pdata[i] = header ? {r[31:28], 8'h00, 4'(len)} : r[31:16];
    end
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    @(negedge clk);
    for (int i = 0; i < NumPorts; i++)
    begin
      r = nextRand();
      req[i] = (r[31:30] != 2'b00);
      fid[i] = (r[29:27] == 3'b000) ? Header : Body;
      pdata[i] = (r[29:27] == 3'b000) ? {r[15:12], 8'h00, r[19:16]} : r[15:0];
    end
  endtask

  task automatic readAll();
    for (int i = 0; i < NumPorts; i++)
      apbAccess(1'b0, AddrWidth'(4 * i), 32'd0);
  endtask

  initial
  begin
    req = '0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      fid[i] = Idle;
      pdata[i] = '0;
    end
    @(negedge rst);
    readAll();
    apbAccess(1'b0, AddrCtrl, 32'd0);
    repeat (8) drivePorts('1, 1'b1, 2);   // disabled, nothing may be granted
    apbAccess(1'b1, AddrCtrl, 32'd1);
    drivePorts(5'b00010, 1'b1, 5);
    repeat (20) drivePorts(5'b00010, 1'b0, 0);
    drivePorts('1, 1'b1, 3);
    repeat (30) drivePorts('1, 1'b0, 0);
    repeat (16) drivePorts(5'b01100, 1'b0, 0);   // west wraps to east
    repeat (2) drivePorts('0, 1'b0, 0);
    repeat (300) randomCycle();
    readAll();
    apbAccess(1'b1, 5'h08, 32'd0);
    repeat (20) randomCycle();
    readAll();
    // unmapped addresses
    apbAccess(1'b1, 5'h18, 32'd0);
    apbAccess(1'b1, 5'h06, 32'hffff_ffff);
    apbAccess(1'b0, 5'h1c, 32'd0);
    readAll();
    apbAccess(1'b0, AddrCtrl, 32'd0);
    apbAccess(1'b1, AddrCtrl, 32'd0);
    repeat (10) randomCycle();
    @(negedge clk);
    assertFails = routerOutputPort_i.apbStatus_i.apbAsserts_i.failCount
      + routerOutputPort_i.outputArbiter_i.arbAsserts_i.failCount;
    $display("errors: %0d from checks, %0d from assertions", errors, assertFails);
    if (errors == 0 && assertFails == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // about 10 reset, 80 directed, 330 random and 100 apb cycles, plus margin
  initial
  begin
    #((10 + 80 + 330 + 100 + 200) * 20);
    $display("watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

endmodule
